/* Bender.yml */
package:
  name: board_ctrl

sources:
  - verilog/board_pkg.sv
  - verilog/board_input_sync.sv
  - verilog/board_regs.sv
  - verilog/amp_power_seq.sv
  - verilog/board_ctrl_top.sv
  - target: test
    files:
      - tests/board_ctrl_checker.sv
      - tests/tb_board_ctrl.sv

/* filelist.f */
verilog/board_pkg.sv
verilog/board_input_sync.sv
verilog/board_regs.sv
verilog/amp_power_seq.sv
verilog/board_ctrl_top.sv
tests/board_ctrl_checker.sv
tests/tb_board_ctrl.sv

/* tests/board_ctrl_checker.sv */
// ----------------------------------------------------------------------
// watches every DUT port, keeps its own model of the register rules
// samples 10 ns after each rising edge, inputs only move on falling edges
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_ctrl_checker #(
    parameter logic [3:0]           NUM_CHAN      = 4'd8,
    parameter board_pkg::reg_data_t VERSION       = 32'h44514C41,
    parameter int                   SETTLE_CYCLES = 20
) (
    input  logic                 sysclk,
    input  logic                 rst,
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_addr_t reg_waddr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    input  board_pkg::reg_data_t reg_rdata,
    input  board_pkg::digin_t    neg_limit,
    input  board_pkg::digin_t    pos_limit,
    input  board_pkg::digin_t    home,
    input  board_pkg::half_t     mv_good,
    input  board_pkg::half_t     safety_fb,
    input  board_pkg::reg_data_t dout,
    input  board_pkg::half_t     dout_cfg_valid,
    input  board_pkg::half_t     dout_cfg_bidir,
    input  board_pkg::half_t     isquad_dac,
    input  board_pkg::half_t     ioexp_present,
    input  board_pkg::half_t     dqla_exp_ok,
    input  board_pkg::half_t     mv_fb,
    input  logic [3:0]           board_id,
    input  board_pkg::reg_data_t temp_sense,
    input  board_pkg::reg_data_t ds_status,
    input  logic                 wdog_timeout,
    input  logic                 relay_on,
    input  board_pkg::half_t     pwr_enable,
    input  logic                 dout_cfg_reset,
    input  logic                 dac_test_reset,
    input  logic                 ioexp_cfg_reset,
    input  logic                 pwr_enable_cmd,
    input  board_pkg::reg_data_t reg_status,
    input  board_pkg::reg_data_t reg_digin,
    input  board_pkg::half_t     mv_amp_disable,
    input  logic                 chk_en,       // end of a table row
    input  logic                 exp_relay,
    input  board_pkg::half_t     exp_pwr,
    input  board_pkg::half_t     exp_dis,
    output int                   err_count = 0,
    output int                   check_count = 0
);

    // model of the two sync stages
    board_pkg::digin_t neg_m = '0, neg_s = '0, pos_m = '0, pos_s = '0, home_m = '0, home_s = '0;
    board_pkg::half_t  mv_m = '0, mv_s = '0, sf_m = '0, sf_s = '0;
    logic              relay = 1'b0;
    board_pkg::half_t  pwr = '0;
    logic [2:0]        req = '0;          // {dout_cfg, dac_test, ioexp}
    board_pkg::reg_data_t rdata = '0;
    int                run_cnt [1:2] = '{0, 0};  // edges with mv_s high in a row
    logic              started = 1'b0;

    function automatic board_pkg::reg_data_t status_word();
        return {NUM_CHAN, board_id,
                wdog_timeout, isquad_dac, 1'b0, &mv_s, &pwr, 1'b0, relay,
                mv_s, dqla_exp_ok, dout_cfg_valid, dout_cfg_bidir,
                sf_s, mv_fb, dout[31], 1'b0, ioexp_present};
    endfunction

    function automatic board_pkg::reg_data_t digin_word();
        return {dout[7:4], neg_s[7:4], pos_s[7:4], home_s[7:4],
                dout[3:0], neg_s[3:0], pos_s[3:0], home_s[3:0]};
    endfunction

    task automatic report(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic cmp(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            report($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // model step and compare
    // ------------------------------------------------------------------

    always @(posedge sysclk) begin : step
        logic                 wmain;
        logic                 wstat;
        board_pkg::reg_data_t st_pre;
        board_pkg::reg_data_t dg_pre;
        board_pkg::half_t     dis;
        #10;                                  // DUT flops have settled
        st_pre = status_word();               // read words as seen before the edge
        dg_pre = digin_word();
        wmain  = reg_wen && (reg_waddr[15:12] == board_pkg::ADDR_MAIN)
                 && (reg_waddr[7:4] == 4'd0);
        wstat  = wmain && (reg_waddr[3:0] == board_pkg::REG_STATUS);
        if (rst) begin
            {neg_m, neg_s, pos_m, pos_s, home_m, home_s} = '0;
            {mv_m, mv_s, sf_m, sf_s} = '0;
            relay = 1'b0;
            pwr   = '0;
            req   = '0;
            rdata = '0;
            run_cnt = '{0, 0};
        end else begin
            if (wstat) begin
                if (reg_wdata[17]) relay = reg_wdata[16];
                if (reg_wdata[19]) pwr = {2{reg_wdata[18]}};
                req = {reg_wdata[24], reg_wdata[22], reg_wdata[23]};
            end else if (!wmain) begin
                req = '0;
                case (reg_raddr[3:0])
                    4'd0:    rdata = st_pre;
                    4'd6:    rdata = dout;
                    4'd7:    rdata = VERSION;
                    4'd8:    rdata = temp_sense;
                    4'd10:   rdata = dg_pre;
                    4'd11:   rdata = ds_status;
                    default: rdata = '0;
                endcase
            end
            for (int h = 1; h <= 2; h++) begin
                run_cnt[h] = mv_s[h] ? run_cnt[h] + 1 : 0;  // counts edges seen high
            end
            {neg_s, pos_s, home_s, mv_s, sf_s} = {neg_m, pos_m, home_m, mv_m, sf_m};
            {neg_m, pos_m, home_m, mv_m, sf_m} = {neg_limit, pos_limit, home, mv_good, safety_fb};
        end
        // amps run once SETTLE_CYCLES+1 edges saw voltage
        for (int h = 1; h <= 2; h++) begin
            dis[h] = (run_cnt[h] < SETTLE_CYCLES + 1);
        end
        if (started) begin
            cmp("reg_rdata", reg_rdata, rdata);
            cmp("relay_on", relay_on, relay);
            cmp("pwr_enable", pwr_enable, pwr);
            cmp("request pulses", {dout_cfg_reset, dac_test_reset, ioexp_cfg_reset}, req);
            cmp("pwr_enable_cmd", pwr_enable_cmd, wstat && reg_wdata[19] && reg_wdata[18]);
            cmp("reg_status", reg_status, status_word());
            cmp("reg_digin", reg_digin, digin_word());
            cmp("mv_amp_disable", mv_amp_disable, dis);
            if (chk_en) begin
                cmp("row relay_on", relay_on, exp_relay);
                cmp("row pwr_enable", pwr_enable, exp_pwr);
                cmp("row mv_amp_disable", mv_amp_disable, exp_dis);
            end
        end
        started = 1'b1;
    end

endmodule

/* tests/tb_board_ctrl.sv */
// ----------------------------------------------------------------------
// testbench for board_ctrl_top, stimulus rows applied on falling edges
// SETTLE_CYCLES shortened to 20, status inputs random per row
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_board_ctrl;

    localparam int SETTLE = 20;

    logic                 sysclk, rst, reg_wen, wdog_timeout, relay_on;
    board_pkg::reg_addr_t reg_raddr, reg_waddr;
    board_pkg::reg_data_t reg_wdata, reg_rdata, dout, temp_sense, ds_status;
    board_pkg::reg_data_t reg_status, reg_digin;
    board_pkg::digin_t    neg_limit, pos_limit, home;
    board_pkg::half_t     mv_good, safety_fb, dout_cfg_valid, dout_cfg_bidir;
    board_pkg::half_t     isquad_dac, ioexp_present, dqla_exp_ok, mv_fb;
    board_pkg::half_t     pwr_enable, mv_amp_disable, exp_pwr, exp_dis;
    logic [3:0]           board_id;
    logic                 dout_cfg_reset, dac_test_reset, ioexp_cfg_reset, pwr_enable_cmd;
    logic                 chk_en, exp_relay;
    int                   err_count, check_count;
    int                   seed = 41;          // fixed seed for $urandom
    logic                 table_ready = 1'b0;

    // stimulus table, one entry per row
    logic [15:0] t_waddr [$];
    logic [31:0] t_wdata [$];
    logic        t_wen   [$];
    logic [15:0] t_raddr [$];
    logic [7:0]  t_neg [$], t_pos [$], t_home [$];
    logic [1:0]  t_mv [$], t_sfb [$], t_epwr [$], t_edis [$];
    int          t_hold  [$];
    logic        t_erelay [$];

    board_ctrl_top #(.SETTLE_CYCLES(SETTLE)) dut0 (.*);

    board_ctrl_checker #(.SETTLE_CYCLES(SETTLE)) u_check (.*);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    task automatic add_row(input logic [15:0] wa, input logic [31:0] wd, input logic we,
                           input logic [15:0] ra, input logic [7:0] ng, input logic [7:0] ps,
                           input logic [7:0] hm, input logic [1:0] mv, input logic [1:0] sf,
                           input int hold, input logic er, input logic [1:0] ep,
                           input logic [1:0] ed);
        t_waddr.push_back(wa);
        t_wdata.push_back(wd);
        t_wen.push_back(we);
        t_raddr.push_back(ra);
        t_neg.push_back(ng);
        t_pos.push_back(ps);
        t_home.push_back(hm);
        t_mv.push_back(mv);
        t_sfb.push_back(sf);
        t_hold.push_back(hold);
        t_erelay.push_back(er);
        t_epwr.push_back(ep);
        t_edis.push_back(ed);
    endtask

    task automatic random_status();
        dout           = $urandom;
        temp_sense     = $urandom;
        ds_status      = $urandom;
        board_id       = $urandom;
        wdog_timeout   = $urandom;
        {dout_cfg_valid, dout_cfg_bidir, isquad_dac} = $urandom;
        {ioexp_present, dqla_exp_ok, mv_fb}          = $urandom;
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(seed));
        rst = 1'b1;
        {reg_raddr, reg_waddr, reg_wdata, reg_wen} = '0;
        {neg_limit, pos_limit, home, mv_good, safety_fb} = '0;
        {chk_en, exp_relay, exp_pwr, exp_dis} = '0;
        random_status();
        //      waddr    wdata         we raddr   neg    pos    home   mv     sfb   hold rel pwr  dis
        add_row(16'h0, 32'h0,        0, 16'h7, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 2, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h8, 8'h0,  8'h0,  8'h0,  2'b00, 2'b10, 2, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'hB, 8'h0,  8'h0,  8'h0,  2'b00, 2'b01, 2, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h6, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 2, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h3, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 2, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h00030000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 1, 2'b00, 2'b11);
        add_row(16'h0, 32'h00000000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 1, 2'b00, 2'b11);
        add_row(16'h0, 32'h000C0000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 1, 2'b11, 2'b11);
        add_row(16'h0, 32'h00400000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 1, 2'b11, 2'b11);
        add_row(16'h0, 32'h00800000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 1, 2'b11, 2'b11);
        add_row(16'h0, 32'h01000000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 1, 2'b11, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 2, 1, 2'b11, 2'b11);
        add_row(16'h1000, 32'h01C20000, 1, 16'h0, 8'h0, 8'h0, 8'h0, 2'b00, 2'b00, 1, 1, 2'b11, 2'b11);
        add_row(16'h0010, 32'h01C20000, 1, 16'h0, 8'h0, 8'h0, 8'h0, 2'b00, 2'b00, 1, 1, 2'b11, 2'b11);
        add_row(16'h0, 32'h00020000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 0, 2'b11, 2'b11);
        add_row(16'h0, 32'h00080000, 1, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 1, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'hA, 8'hA5, 8'h3C, 8'h81, 2'b00, 2'b00, 4, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h0, 8'hA5, 8'h3C, 8'h81, 2'b11, 2'b00, 10, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h0, 8'hA5, 8'h3C, 8'h81, 2'b01, 2'b00, 5, 0, 2'b00, 2'b11);
        add_row(16'h0, 32'h0,        0, 16'h0, 8'hA5, 8'h3C, 8'h81, 2'b11, 2'b00, 30, 0, 2'b00, 2'b00);
        add_row(16'h0, 32'h0,        0, 16'h0, 8'hA5, 8'h3C, 8'h81, 2'b10, 2'b00, 4, 0, 2'b00, 2'b01);
        add_row(16'h0, 32'h0,        0, 16'h0, 8'h0,  8'h0,  8'h0,  2'b00, 2'b00, 4, 0, 2'b00, 2'b11);
        table_ready = 1'b1;
        repeat (10) @(negedge sysclk);
        rst = 1'b0;
        foreach (t_hold[r]) begin
            for (int c = 0; c < t_hold[r]; c++) begin
                @(negedge sysclk);
                if (c == 0) random_status();   // status inputs stay put within a row
                reg_waddr = t_waddr[r];
                reg_wdata = t_wdata[r];
                reg_wen   = t_wen[r];
                reg_raddr = t_raddr[r];
                {neg_limit, pos_limit, home} = {t_neg[r], t_pos[r], t_home[r]};
                {mv_good, safety_fb} = {t_mv[r], t_sfb[r]};
                chk_en    = (c == t_hold[r] - 1);
                {exp_relay, exp_pwr, exp_dis} = {t_erelay[r], t_epwr[r], t_edis[r]};
            end
        end
        @(negedge sysclk);
        chk_en  = 1'b0;
        reg_wen = 1'b0;
        repeat (3) @(negedge sysclk);
        $display("checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // ------------------------------------------------------------------
    // watchdog, sized from the table
    // ------------------------------------------------------------------

    initial begin : watchdog
        int max_hold;
        int limit;
        wait (table_ready);
        max_hold = 0;
        foreach (t_hold[r]) begin
            if (t_hold[r] > max_hold) max_hold = t_hold[r];
        end
        limit = 10 + t_hold.size() * max_hold + 50;
        repeat (limit) @(posedge sysclk);
        $display("Timeout: the run did not end within %0d clock cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verilog/amp_power_seq.sv */
// ----------------------------------------------------------------------
// holds each half's amplifiers off until its motor voltage has settled
// mv_good_s must come from the synchronizer, SETTLE_CYCLES must be >= 1
// disable clears SETTLE_CYCLES+1 clocks after mv_good_s rises
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module amp_power_seq #(
    parameter int SETTLE_CYCLES = 1966080   // 40 ms at 49.152 MHz
) (
    input  logic             sysclk,
    input  logic             rst,
    input  board_pkg::half_t mv_good_s,       // synchronized motor voltage good
    output board_pkg::half_t mv_amp_disable   // 1 = amps held off
);

    // counter runs 0 .. SETTLE_CYCLES-1
    localparam int CNT_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SETTLE_CYCLES - 1);

    // ------------------------------------------------------------------
    // one FSM and counter per half
    // ------------------------------------------------------------------

    for (genvar i = 1; i <= 2; i++) begin : g_half

        board_pkg::seq_state_e state;
        logic [CNT_W-1:0]      settle_cnt;

        always_ff @(posedge sysclk) begin
            if (rst) begin
                state      <= board_pkg::SEQ_OFF;
                settle_cnt <= '0;
            end else if (!mv_good_s[i]) begin
                // voltage lost, start over from any state
                state      <= board_pkg::SEQ_OFF;
                settle_cnt <= '0;
            end else begin
                case (state)
                    board_pkg::SEQ_OFF: begin
                        state      <= board_pkg::SEQ_SETTLING;
                        settle_cnt <= '0;   // first clock with voltage present
                    end
                    board_pkg::SEQ_SETTLING: begin
                        if (settle_cnt == CNT_LAST) begin
                            state <= board_pkg::SEQ_READY;
                        end else begin
                            settle_cnt <= settle_cnt + 1'b1;
                        end
                    end
                    board_pkg::SEQ_READY: begin
                        state <= board_pkg::SEQ_READY;  // stay while voltage holds
                    end
                    default: begin
                        state      <= board_pkg::SEQ_OFF;
                        settle_cnt <= '0;
                    end
                endcase
            end
        end

        // state is a flop, so the disable is glitch free
        assign mv_amp_disable[i] = (state != board_pkg::SEQ_READY);

        // ready is only reached, and only kept, with voltage present
        a_ready_needs_mv: assert property (@(posedge sysclk) disable iff (rst)
            (state == board_pkg::SEQ_READY) |-> $past(mv_good_s[i]));

    end

endmodule

/* verilog/board_ctrl_top.sv */
// ----------------------------------------------------------------------
// board register block top: input sync, register file, amp sequencer
// all board inputs are taken as asynchronous except the host bus
// raw mv_good rise to amp enable is SETTLE_CYCLES+3 clocks
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_ctrl_top #(
    parameter logic [3:0]           NUM_CHAN      = 4'd8,
    parameter board_pkg::reg_data_t VERSION       = 32'h44514C41,  // "DQLA"
    parameter int                   SETTLE_CYCLES = 1966080
) (
    input  logic                 sysclk,
    input  logic                 rst,

    // host bus
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_addr_t reg_waddr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    output board_pkg::reg_data_t reg_rdata,

    // raw board inputs
    input  board_pkg::digin_t    neg_limit,
    input  board_pkg::digin_t    pos_limit,
    input  board_pkg::digin_t    home,
    input  board_pkg::half_t     mv_good,
    input  board_pkg::half_t     safety_fb,

    // status from other engines
    input  board_pkg::reg_data_t dout,
    input  board_pkg::half_t     dout_cfg_valid,
    input  board_pkg::half_t     dout_cfg_bidir,
    input  board_pkg::half_t     isquad_dac,
    input  board_pkg::half_t     ioexp_present,
    input  board_pkg::half_t     dqla_exp_ok,
    input  board_pkg::half_t     mv_fb,
    input  logic [3:0]           board_id,
    input  board_pkg::reg_data_t temp_sense,
    input  board_pkg::reg_data_t ds_status,
    input  logic                 wdog_timeout,

    // outputs
    output logic                 relay_on,
    output board_pkg::half_t     pwr_enable,
    output logic                 dout_cfg_reset,
    output logic                 dac_test_reset,
    output logic                 ioexp_cfg_reset,
    output logic                 pwr_enable_cmd,
    output board_pkg::reg_data_t reg_status,
    output board_pkg::reg_data_t reg_digin,
    output board_pkg::half_t     mv_amp_disable
);

    // synchronized copies
    board_pkg::digin_t neg_limit_s;
    board_pkg::digin_t pos_limit_s;
    board_pkg::digin_t home_s;
    board_pkg::half_t  mv_good_s;     // shared by regs and sequencer
    board_pkg::half_t  safety_fb_s;

    board_input_sync u_sync (
        .sysclk      (sysclk),
        .rst         (rst),
        .neg_limit   (neg_limit),
        .pos_limit   (pos_limit),
        .home        (home),
        .mv_good     (mv_good),
        .safety_fb   (safety_fb),
        .neg_limit_s (neg_limit_s),
        .pos_limit_s (pos_limit_s),
        .home_s      (home_s),
        .mv_good_s   (mv_good_s),
        .safety_fb_s (safety_fb_s)
    );

    board_regs #(
        .NUM_CHAN (NUM_CHAN),
        .VERSION  (VERSION)
    ) u_regs (
        .sysclk          (sysclk),
        .rst             (rst),
        .reg_raddr       (reg_raddr),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .reg_rdata       (reg_rdata),
        .dout            (dout),
        .dout_cfg_valid  (dout_cfg_valid),
        .dout_cfg_bidir  (dout_cfg_bidir),
        .isquad_dac      (isquad_dac),
        .ioexp_present   (ioexp_present),
        .dqla_exp_ok     (dqla_exp_ok),
        .mv_fb           (mv_fb),
        .mv_good_s       (mv_good_s),
        .safety_fb_s     (safety_fb_s),
        .neg_limit_s     (neg_limit_s),
        .pos_limit_s     (pos_limit_s),
        .home_s          (home_s),
        .board_id        (board_id),
        .temp_sense      (temp_sense),
        .ds_status       (ds_status),
        .wdog_timeout    (wdog_timeout),
        .relay_on        (relay_on),
        .pwr_enable      (pwr_enable),
        .dout_cfg_reset  (dout_cfg_reset),
        .dac_test_reset  (dac_test_reset),
        .ioexp_cfg_reset (ioexp_cfg_reset),
        .pwr_enable_cmd  (pwr_enable_cmd),
        .reg_status      (reg_status),
        .reg_digin       (reg_digin)
    );

    amp_power_seq #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_seq (
        .sysclk         (sysclk),
        .rst            (rst),
        .mv_good_s      (mv_good_s),
        .mv_amp_disable (mv_amp_disable)
    );

endmodule

/* verilog/board_input_sync.sv */
// ----------------------------------------------------------------------
// two flop synchronizer for the asynchronous board inputs
// fixed latency of 2 sysclk edges, no filtering or debounce
// bits of a bus are synced independently, so multi-bit skew is possible
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_input_sync (
    input  logic              sysclk,
    input  logic              rst,
    input  board_pkg::digin_t neg_limit,    // raw negative limit switches
    input  board_pkg::digin_t pos_limit,    // raw positive limit switches
    input  board_pkg::digin_t home,         // raw home switches
    input  board_pkg::half_t  mv_good,      // raw motor voltage good, per half
    input  board_pkg::half_t  safety_fb,    // raw safety line feedback
    output board_pkg::digin_t neg_limit_s,
    output board_pkg::digin_t pos_limit_s,
    output board_pkg::digin_t home_s,
    output board_pkg::half_t  mv_good_s,
    output board_pkg::half_t  safety_fb_s
);

    // all inputs share one pair of stages
    localparam int SYNC_W = 3 * $bits(board_pkg::digin_t)
                          + 2 * $bits(board_pkg::half_t);

    logic [SYNC_W-1:0] raw_vec;   // concatenated raw inputs
    logic [SYNC_W-1:0] meta_q;    // first stage, may go metastable
    logic [SYNC_W-1:0] sync_q;    // second stage, safe to use

    assign raw_vec = {neg_limit, pos_limit, home, mv_good, safety_fb};

    // ------------------------------------------------------------------
    // synchronizer stages
    // ------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= raw_vec;
            sync_q <= meta_q;     // output changes 2 edges after input
        end
    end

    // split back out in the same order as packed
    assign {neg_limit_s, pos_limit_s, home_s, mv_good_s, safety_fb_s} = sync_q;

endmodule

/* verilog/board_pkg.sv */
// ----------------------------------------------------------------------
// address map and typed widths for the dual motor-controller board block
// only the main block (address bits 15..12 == ADDR_MAIN) is decoded here
// ----------------------------------------------------------------------
package board_pkg;

    // ------------------------------------------------------------------
    // widths that carry a meaning
    // ------------------------------------------------------------------

    typedef logic [15:0] reg_addr_t;    // host read/write address
    typedef logic [31:0] reg_data_t;    // one register word
    typedef logic [3:0]  reg_offset_t;  // offset within main block, addr bits 3..0

    // halves are numbered 1 and 2 on the board, so index from 1
    typedef logic [2:1]  half_t;

    typedef logic [7:0]  digin_t;       // one bit per limit/home channel

    // ------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------

    localparam logic [3:0] ADDR_MAIN = 4'd0;  // compared against addr bits 15..12

    // register offsets in the main block
    localparam reg_offset_t REG_STATUS  = 4'd0;   // levels, requests, board status
    localparam reg_offset_t REG_DIGIOUT = 4'd6;   // digital-out readback
    localparam reg_offset_t REG_VERSION = 4'd7;   // firmware version word
    localparam reg_offset_t REG_TEMPSNS = 4'd8;   // temperature sensor
    localparam reg_offset_t REG_DIGIN   = 4'd10;  // packed limit/home/dout
    localparam reg_offset_t REG_DSSTAT  = 4'd11;  // dallas chip status

    // status write bit positions
    // 16/17 relay value/mask, 18/19 power value/mask
    // 22 dac test, 23 i/o expander redetect, 24 dout config reset

    // ------------------------------------------------------------------
    // amplifier power sequencer
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        SEQ_OFF      = 2'd0,  // motor voltage absent, amps held off
        SEQ_SETTLING = 2'd1,  // voltage present, waiting out settle time
        SEQ_READY    = 2'd2   // settled, amps may run
    } seq_state_e;

endpackage

/* verilog/board_regs.sv */
// ----------------------------------------------------------------------
// host register file of the board, one access per clock, no handshake
// writes to the main block win over reads, reg_rdata holds during a write
// request pulses last one clock unless main writes repeat back to back
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module board_regs #(
    parameter logic [3:0]          NUM_CHAN = 4'd8,          // reported in status byte 3
    parameter board_pkg::reg_data_t VERSION = 32'h44514C41   // ascii "DQLA"
) (
    input  logic                 sysclk,
    input  logic                 rst,

    // host bus
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_addr_t reg_waddr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    output board_pkg::reg_data_t reg_rdata,       // registered, 1 clock after raddr

    // status from the other engines
    input  board_pkg::reg_data_t dout,            // digital outputs as driven
    input  board_pkg::half_t     dout_cfg_valid,
    input  board_pkg::half_t     dout_cfg_bidir,
    input  board_pkg::half_t     isquad_dac,      // dac type per half
    input  board_pkg::half_t     ioexp_present,
    input  board_pkg::half_t     dqla_exp_ok,
    input  board_pkg::half_t     mv_fb,           // motor supply comparator
    input  board_pkg::half_t     mv_good_s,       // already synchronized
    input  board_pkg::half_t     safety_fb_s,
    input  board_pkg::digin_t    neg_limit_s,
    input  board_pkg::digin_t    pos_limit_s,
    input  board_pkg::digin_t    home_s,
    input  logic [3:0]           board_id,        // rotary switch
    input  board_pkg::reg_data_t temp_sense,
    input  board_pkg::reg_data_t ds_status,
    input  logic                 wdog_timeout,

    // levels and requests
    output logic                 relay_on,        // safety relay
    output board_pkg::half_t     pwr_enable,      // both bits always move together
    output logic                 dout_cfg_reset,
    output logic                 dac_test_reset,
    output logic                 ioexp_cfg_reset,
    output logic                 pwr_enable_cmd,  // same-cycle power-on attempt
    output board_pkg::reg_data_t reg_status,
    output board_pkg::reg_data_t reg_digin
);

    // ------------------------------------------------------------------
    // packed read words
    // ------------------------------------------------------------------

    // host software expects board_id at 27..24 and wdog_timeout at 23
    assign reg_status = {
        NUM_CHAN, board_id,                                   // byte 3
        wdog_timeout, isquad_dac, 1'b0,                       // byte 2
        (&mv_good_s), (&pwr_enable), 1'b0, relay_on,
        mv_good_s, dqla_exp_ok, dout_cfg_valid, dout_cfg_bidir, // byte 1
        safety_fb_s, mv_fb, dout[31], 1'b0, ioexp_present     // byte 0
    };
    // dout[31] flags the waveform table driving a dout

    // nibble-interleaved so each group of 4 channels is one half-word
    assign reg_digin = {dout[7:4], neg_limit_s[7:4], pos_limit_s[7:4], home_s[7:4],
                        dout[3:0], neg_limit_s[3:0], pos_limit_s[3:0], home_s[3:0]};

    // ------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------

    board_pkg::reg_offset_t wr_offset;   // write offset in main block
    board_pkg::reg_offset_t rd_offset;   // read offset, upper bits ignored
    logic                   write_main;
    logic                   write_status;

    assign wr_offset = reg_waddr[3:0];
    assign rd_offset = reg_raddr[3:0];

    // bits 7..4 must be zero, other sub-blocks live there
    assign write_main = reg_wen
                     && (reg_waddr[15:12] == board_pkg::ADDR_MAIN)
                     && (reg_waddr[7:4] == 4'd0);

    assign write_status = write_main && (wr_offset == board_pkg::REG_STATUS);

    // used elsewhere on the board to clear latched error flags
    assign pwr_enable_cmd = write_status && reg_wdata[19] && reg_wdata[18];

    // ------------------------------------------------------------------
    // register update and read mux
    // ------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (rst) begin
            relay_on        <= 1'b0;
            pwr_enable      <= '0;
            dout_cfg_reset  <= 1'b0;
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
            reg_rdata       <= '0;
        end else if (write_main) begin
            // writes to other main offsets leave everything as is
            if (write_status) begin
                if (reg_wdata[17]) begin
                    relay_on <= reg_wdata[16];            // masked relay control
                end
                if (reg_wdata[19]) begin
                    pwr_enable <= {2{reg_wdata[18]}};     // masked power enable
                end
                dac_test_reset  <= reg_wdata[22];         // rerun dac test
                ioexp_cfg_reset <= reg_wdata[23];         // redetect i/o expander
                dout_cfg_reset  <= reg_wdata[24];         // clear dout_cfg_valid
            end
        end else begin
            case (rd_offset)
                board_pkg::REG_STATUS:  reg_rdata <= reg_status;
                board_pkg::REG_VERSION: reg_rdata <= VERSION;
                board_pkg::REG_TEMPSNS: reg_rdata <= temp_sense;
                board_pkg::REG_DIGIOUT: reg_rdata <= dout;
                board_pkg::REG_DSSTAT:  reg_rdata <= ds_status;
                board_pkg::REG_DIGIN:   reg_rdata <= reg_digin;
                default:                reg_rdata <= '0;  // unmapped reads zero
            endcase
            // no write this cycle, so drop any request
            dout_cfg_reset  <= 1'b0;
            dac_test_reset  <= 1'b0;
            ioexp_cfg_reset <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    logic [2:0] req_vec;
    assign req_vec = {dout_cfg_reset, dac_test_reset, ioexp_cfg_reset};

    // a request held over two clocks needs a main write between them
    a_req_one_clock: assert property (@(posedge sysclk) disable iff (rst)
        |(req_vec & $past(req_vec)) |-> $past(write_main));

    a_pwr_halves_equal: assert property (@(posedge sysclk) disable iff (rst)
        pwr_enable[1] == pwr_enable[2]);

endmodule
